// ==== aluDecoder.sv ====
`timescale 1ns/100ps

module aluDecoder
  import isaPkg::*, ctrlPkg::*;
(
  input  logic       aluOp,
  input  dpOpT       opcode,
  input  logic [1:0] prevCV,
  output aluOpT      aluOperation,
  output logic       cvUpdate,
  output logic       invertB,
  output logic       reverseInputs,
  output logic       aluCarry,
  output logic       doNotWriteReg
);

  // Subtraction is A + ~B + carry, so borrow forms reuse the held C
  always_comb begin
    aluOperation  = aluAdd;
    cvUpdate      = 1'b0;
    invertB       = 1'b0;
    reverseInputs = 1'b0;
    aluCarry      = 1'b0;
    doNotWriteReg = 1'b0;
    if (aluOp) begin
      case (opcode)
        opAnd: aluOperation = aluAnd;
        opEor: aluOperation = aluXor;
        opSub, opCmp: begin
          aluOperation = aluSub;
          cvUpdate     = 1'b1;
          invertB      = 1'b1;
          aluCarry     = 1'b1;
        end
        opRsb: begin
          aluOperation  = aluSub;
          cvUpdate      = 1'b1;
          invertB       = 1'b1;
          reverseInputs = 1'b1;  // B - A
          aluCarry      = 1'b1;
        end
        opAdd, opCmn: cvUpdate = 1'b1;
        opAdc: begin
          cvUpdate = 1'b1;
          aluCarry = prevCV[1];
        end
        opSbc: begin
          aluOperation = aluSub;
          cvUpdate     = 1'b1;
          invertB      = 1'b1;
          aluCarry     = prevCV[1];
        end
        opRsc: begin
          aluOperation  = aluSub;
          cvUpdate      = 1'b1;
          invertB       = 1'b1;
          reverseInputs = 1'b1;
          aluCarry      = prevCV[1];
        end
        opTst: aluOperation = aluAnd;
        opTeq: aluOperation = aluXor;
        opOrr: aluOperation = aluOr;
        opMov: aluOperation = aluPass;
        opBic: begin
          aluOperation = aluAnd;
          invertB      = 1'b1;  // A & ~B
        end
        opMvn: begin
          aluOperation = aluPass;
          invertB      = 1'b1;
        end
        default: aluOperation = aluAdd;
      endcase
      // Compare and test only touch the flags
      doNotWriteReg = (opcode == opTst) | (opcode == opTeq) |
                      (opcode == opCmp) | (opcode == opCmn);
    end
  end

endmodule

// ==== armController.sv ====
`timescale 1ns/100ps

module armController
  import isaPkg::*, ctrlPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  instrT      instrD,
  input  flagsT      flagsE,
  input  regIdxT     regFileRzD,
  input  logic       prevRsrStateD,
  input  logic       stallE,
  input  logic       flushE,
  input  logic       stallM,
  input  logic       stallW,
  input  logic       flushW,
  output logic [1:0] regSrcD,
  output logic [1:0] immSrcD,
  output logic       multSelectD,
  output logic       aluSrcE,
  output dpOpT       aluControlE,
  output aluOpT      aluOperationE,
  output logic       cvUpdateE,
  output logic       invertBE,
  output logic       reverseInputsE,
  output logic       aluCarryE,
  output resultSelT  resultSelectE,
  output logic       rSelectE,
  output logic       prevRsrStateE,
  output logic       branchTakenE,
  output logic       multEnable,
  output instrT      instrE,
  output flagsT      previousFlagsE,
  output logic       memWriteM,
  output logic       memToRegE,
  output logic       memToRegM,
  output logic       regWriteM,
  output logic       memToRegW,
  output logic       regWriteW,
  output logic       pcSrcW,
  output logic       pcWrPendingF
);

  ctrlBundleIf bundleD ();

  logic      aluOpE;
  flagWriteT flagWriteE;
  condT      condE;
  logic      condExE;
  logic      doNotWriteRegE;

  mainDecoder i_mainDecoder (
    .instr      (instrD),
    .regFileRz  (regFileRzD),
    .regSrc     (regSrcD),
    .immSrc     (immSrcD),
    .multSelect (multSelectD),
    .bundle     (bundleD.dec)
  );

  ctrlPipe i_ctrlPipe (
    .clk           (clk),
    .rst           (rst),
    .stallE        (stallE),
    .flushE        (flushE),
    .stallM        (stallM),
    .stallW        (stallW),
    .flushW        (flushW),
    .bundle        (bundleD.pipe),
    .condEx        (condExE),
    .doNotWriteReg (doNotWriteRegE),
    .prevRsrStateD (prevRsrStateD),
    .aluSrcE       (aluSrcE),
    .aluOpE        (aluOpE),
    .aluControlE   (aluControlE),
    .flagWriteE    (flagWriteE),
    .condE         (condE),
    .memToRegE     (memToRegE),
    .resultSelectE (resultSelectE),
    .rSelectE      (rSelectE),
    .prevRsrStateE (prevRsrStateE),
    .instrE        (instrE),
    .pcSrcE        (),
    .branchTakenE  (branchTakenE),
    .multEnable    (multEnable),
    .memWriteM     (memWriteM),
    .memToRegM     (memToRegM),
    .regWriteM     (regWriteM),
    .pcSrcM        (),
    .memToRegW     (memToRegW),
    .regWriteW     (regWriteW),
    .pcSrcW        (pcSrcW),
    .pcWrPendingF  (pcWrPendingF)
  );

  aluDecoder i_aluDecoder (
    .aluOp         (aluOpE),
    .opcode        (aluControlE),
    .prevCV        (previousFlagsE[1:0]),  // Held C and V
    .aluOperation  (aluOperationE),
    .cvUpdate      (cvUpdateE),
    .invertB       (invertBE),
    .reverseInputs (reverseInputsE),
    .aluCarry      (aluCarryE),
    .doNotWriteReg (doNotWriteRegE)
  );

  condUnit i_condUnit (
    .clk       (clk),
    .rst       (rst),
    .enable    (~stallE),
    .cond      (condE),
    .flagsE    (flagsE),
    .flagWrite (flagWriteE),
    .cvUpdate  (cvUpdateE),
    .condEx    (condExE),
    .flags     (previousFlagsE)
  );

endmodule

// ==== armController_sva.sv ====
`timescale 1ns/100ps

module armController_sva
  import isaPkg::*, ctrlPkg::*;
(
  input logic       clk,
  input logic       rst,
  input instrT      instrD,
  input flagsT      flagsE,
  input regIdxT     regFileRzD,
  input logic       prevRsrStateD,
  input logic       stallE,
  input logic       flushE,
  input logic       stallM,
  input logic       stallW,
  input logic       flushW,
  input logic [1:0] regSrcD,
  input logic [1:0] immSrcD,
  input logic       multSelectD,
  input logic       aluSrcE,
  input dpOpT       aluControlE,
  input aluOpT      aluOperationE,
  input logic       cvUpdateE,
  input logic       invertBE,
  input logic       reverseInputsE,
  input logic       aluCarryE,
  input resultSelT  resultSelectE,
  input logic       rSelectE,
  input logic       prevRsrStateE,
  input logic       multEnable,
  input instrT      instrE,
  input flagsT      previousFlagsE,
  input logic       branchTakenE,
  input logic       memToRegE,
  input logic       memWriteM,
  input logic       memToRegM,
  input logic       regWriteM,
  input logic       memToRegW,
  input logic       regWriteW,
  input logic       pcSrcW,
  input logic       pcWrPendingF
);

  int    failCount = 0;  // Read by the testbench
  flagsT shadowFlags;    // Expected NZCV
  logic  validE;         // Execute holds a real instruction
  logic  pcSrcShadowE;
  logic  pcSrcShadowM;
  logic  passE;
  logic  regWriteExpE;
  logic  memWriteShM;
  logic  memToRegShM;
  logic  regWriteShM;
  logic  memToRegShW;
  logic  regWriteShW;
  logic  pcSrcShW;

  // ARM condition table, f is {N, Z, C, V}
  function automatic logic condPass(logic [3:0] cond, flagsT f);
    case (cond)
      4'h0:    return f[2];
      4'h1:    return !f[2];
      4'h2:    return f[1];
      4'h3:    return !f[1];
      4'h4:    return f[3];
      4'h5:    return !f[3];
      4'h6:    return f[0];
      4'h7:    return !f[0];
      4'h8:    return f[1] && !f[2];
      4'h9:    return !f[1] || f[2];
      4'hA:    return f[3] == f[0];
      4'hB:    return f[3] != f[0];
      4'hC:    return !f[2] && (f[3] == f[0]);
      4'hD:    return f[2] || (f[3] != f[0]);
      4'hE:    return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // {regSrc, immSrc, multSelect} per class
  function automatic logic [4:0] decodeOf(instrT i);
    case (i[27:26])
      2'b00:   return {4'b0000, !i[25] && (i[7:4] == 4'b1001)};
      2'b01:   return i[20] ? 5'b00010 : 5'b10010;  // LDR or STR
      2'b10:   return 5'b01100;
      default: return 5'b00000;
    endcase
  endfunction

  function automatic logic writesReg(instrT i);
    return (i[27:26] == 2'b00) || ((i[27:26] == 2'b01) && i[20]);
  endfunction

  function automatic logic isMul(instrT i);
    return (i[27:25] == 3'b000) && (i[7:4] == 4'b1001);
  endfunction

  function automatic logic isLoad(instrT i);
    return (i[27:26] == 2'b01) && i[20];
  endfunction

  function automatic logic isStore(instrT i);
    return (i[27:26] == 2'b01) && !i[20];
  endfunction

  function automatic logic pcWriteOf(instrT i, regIdxT rz);
    regIdxT dest;
    dest = isMul(i) ? i[19:16] : i[15:12];
    return (i[27:26] == 2'b10) || (writesReg(i) && (dest == 4'hF) && !rz[2]);
  endfunction

  // TST, TEQ, CMP, CMN
  function automatic logic isCompare(instrT i);
    return (i[27:26] == 2'b00) && (i[24:23] == 2'b10);
  endfunction

  function automatic logic cvOp(logic [3:0] op);
    return ((op >= 4'd2) && (op <= 4'd7)) || (op == 4'hA) || (op == 4'hB);
  endfunction

  function automatic logic [3:0] expAluCtrl(instrT i);
    return (i[27:26] == 2'b00) ? i[24:21] : 4'b0100;  // Add outside DP
  endfunction

  // {operation, cvUpdate, invertB, reverseInputs, carry}
  function automatic logic [6:0] expAluCtl(logic dp, logic [3:0] op, logic cIn);
    if (!dp)
      return {aluAdd, 4'b0000};
    case (op)
      4'h0, 4'h8: return {aluAnd, 4'b0000};
      4'h1, 4'h9: return {aluXor, 4'b0000};
      4'h2, 4'hA: return {aluSub, 4'b1101};  // A + ~B + 1
      4'h3:       return {aluSub, 4'b1111};  // B - A
      4'h4, 4'hB: return {aluAdd, 4'b1000};
      4'h5:       return {aluAdd, 3'b100, cIn};
      4'h6:       return {aluSub, 3'b110, cIn};
      4'h7:       return {aluSub, 3'b111, cIn};
      4'hC:       return {aluOr, 4'b0000};
      4'hD:       return {aluPass, 4'b0000};
      4'hE:       return {aluAnd, 4'b0100};  // A & ~B
      default:    return {aluPass, 4'b0100};
    endcase
  endfunction

  function automatic resultSelT expResultSel(instrT i);
    if (isMul(i))
      return resMult;
    if ((i[27:25] == 3'b000) && i[4])
      return resShift;
    return resAlu;
  endfunction

  assign passE        = condPass(instrE[31:28], shadowFlags);
  assign regWriteExpE = validE && writesReg(instrE) && passE && !isCompare(instrE);

  always_ff @(posedge clk) begin
    if (rst) begin
      shadowFlags  <= '0;
      validE       <= 1'b0;
      pcSrcShadowE <= 1'b0;
      pcSrcShadowM <= 1'b0;
      memWriteShM  <= 1'b0;
      memToRegShM  <= 1'b0;
      regWriteShM  <= 1'b0;
      memToRegShW  <= 1'b0;
      regWriteShW  <= 1'b0;
      pcSrcShW     <= 1'b0;
    end else begin
      if (!stallE && validE && (instrE[27:26] == 2'b00) && instrE[20] && passE) begin
        shadowFlags[3:2] <= flagsE[3:2];
        if (cvOp(instrE[24:21]))
          shadowFlags[1:0] <= flagsE[1:0];  // Arithmetic only
      end
      if (flushE) begin
        validE       <= 1'b0;
        pcSrcShadowE <= 1'b0;
      end else if (!stallE) begin
        validE       <= 1'b1;
        pcSrcShadowE <= pcWriteOf(instrD, regFileRzD);
      end
      if (!stallM) begin
        pcSrcShadowM <= pcSrcShadowE && passE;
        memWriteShM  <= validE && isStore(instrE) && passE;
        memToRegShM  <= validE && isLoad(instrE);
        regWriteShM  <= regWriteExpE;
      end
      if (flushW) begin
        memToRegShW <= 1'b0;
        regWriteShW <= 1'b0;
        pcSrcShW    <= 1'b0;
      end else if (!stallW) begin
        memToRegShW <= memToRegShM;
        regWriteShW <= regWriteShM;
        pcSrcShW    <= pcSrcShadowM;
      end
    end
  end

  decodeChk: assert property (@(posedge clk) disable iff (rst)
    {regSrcD, immSrcD, multSelectD} == decodeOf(instrD))
  else begin
    failCount++;
    $error("Decode class outputs wrong for instr %h", instrD);
  end

  executeLoadChk: assert property (@(posedge clk) disable iff (rst)
    $past(!rst && !stallE && !flushE) |->
      (instrE == $past(instrD)) && (aluControlE == expAluCtrl($past(instrD))) &&
      (prevRsrStateE == $past(prevRsrStateD)))
  else begin
    failCount++;
    $error("Execute stage did not load the Decode bundle");
  end

  stallHoldChk: assert property (@(posedge clk) disable iff (rst)
    $past(!rst && stallE && !flushE) |->
      $stable(instrE) && $stable(aluControlE) && $stable(prevRsrStateE))
  else begin
    failCount++;
    $error("Execute stage changed under stall");
  end

  flushClearChk: assert property (@(posedge clk) disable iff (rst)
    $past(!rst && flushE) |-> (instrE == 32'h0) && !branchTakenE && !prevRsrStateE)
  else begin
    failCount++;
    $error("Execute stage not cleared by flush");
  end

  executeFieldsChk: assert property (@(posedge clk) disable iff (rst)
    (aluSrcE == (validE && ((instrE[27:26] != 2'b00) || instrE[25]))) &&
    (memToRegE == (validE && isLoad(instrE))) &&
    (resultSelectE == (validE ? expResultSel(instrE) : resAlu)) &&
    (rSelectE == (validE && (instrE[27:25] == 3'b000) && !instrE[4])) &&
    (multEnable == (validE && isMul(instrE) && !instrE[23])))
  else begin
    failCount++;
    $error("Execute control fields wrong for instrE %h", instrE);
  end

  aluControlChk: assert property (@(posedge clk) disable iff (rst)
    {aluOperationE, cvUpdateE, invertBE, reverseInputsE, aluCarryE} ==
      expAluCtl(validE && (instrE[27:26] == 2'b00), instrE[24:21], shadowFlags[1]))
  else begin
    failCount++;
    $error("ALU controls wrong for instrE %h", instrE);
  end

  flushDrainChk: assert property (@(posedge clk) disable iff (rst)
    $past(!rst && flushE, 2) && $past(!stallM) |-> !regWriteM && !memWriteM)
  else begin
    failCount++;
    $error("Flushed instruction reached Memory with writes set");
  end

  regWriteGateChk: assert property (@(posedge clk) disable iff (rst)
    $past(!stallM) |-> regWriteM == $past(regWriteExpE))
  else begin
    failCount++;
    $error("regWriteM does not follow the condition gating");
  end

  laterStageChk: assert property (@(posedge clk) disable iff (rst)
    (memWriteM == memWriteShM) && (memToRegM == memToRegShM) &&
    (memToRegW == memToRegShW) && (regWriteW == regWriteShW) && (pcSrcW == pcSrcShW))
  else begin
    failCount++;
    $error("Memory or Writeback control bits wrong");
  end

  branchGateChk: assert property (@(posedge clk) disable iff (rst)
    branchTakenE == (validE && (instrE[27:26] == 2'b10) && passE))
  else begin
    failCount++;
    $error("branchTakenE wrong for instrE %h", instrE);
  end

  flagRegChk: assert property (@(posedge clk) disable iff (rst)
    previousFlagsE == shadowFlags)
  else begin
    failCount++;
    $error("Flag register %b, expected %b", previousFlagsE, shadowFlags);
  end

  pcPendingChk: assert property (@(posedge clk) disable iff (rst)
    pcWrPendingF == (pcWriteOf(instrD, regFileRzD) || pcSrcShadowE || pcSrcShadowM))
  else begin
    failCount++;
    $error("pcWrPendingF does not match the PC writes in flight");
  end

endmodule

bind armController armController_sva svaChecks (.*);

// ==== condUnit.sv ====
`timescale 1ns/100ps

module condUnit
  import isaPkg::*, ctrlPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      enable,
  input  condT      cond,
  input  flagsT     flagsE,
  input  flagWriteT flagWrite,
  input  logic      cvUpdate,
  output logic      condEx,
  output flagsT     flags
);

  logic n;
  logic z;
  logic c;
  logic v;
  logic ge;
  logic nzWrite;
  logic cvWrite;

  assign n  = flags[flagN];
  assign z  = flags[flagZ];
  assign c  = flags[flagC];
  assign v  = flags[flagV];
  assign ge = (n == v);

  always_comb begin
    case (cond)
      condEq:  condEx = z;
      condNe:  condEx = ~z;
      condCs:  condEx = c;
      condCc:  condEx = ~c;
      condMi:  condEx = n;
      condPl:  condEx = ~n;
      condVs:  condEx = v;
      condVc:  condEx = ~v;
      condHi:  condEx = c & ~z;
      condLs:  condEx = ~c | z;
      condGe:  condEx = ge;
      condLt:  condEx = ~ge;
      condGt:  condEx = ~z & ge;
      condLe:  condEx = z | ~ge;
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;  // Unconditional space is never executed here
    endcase
  end

  // Instruction must pass its own condition to update flags
  assign nzWrite = enable & flagWrite[1] & condEx;
  assign cvWrite = enable & flagWrite[0] & cvUpdate & condEx;

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      if (nzWrite) begin
        flags[flagN] <= flagsE[flagN];
        flags[flagZ] <= flagsE[flagZ];
      end
      if (cvWrite) begin  // Logical ops leave C and V alone
        flags[flagC] <= flagsE[flagC];
        flags[flagV] <= flagsE[flagV];
      end
    end
  end

endmodule

// ==== ctrlBundleIf.sv ====
`timescale 1ns/100ps

interface ctrlBundleIf
  import isaPkg::*, ctrlPkg::*;
();

  logic       aluSrc;
  logic       memToReg;
  logic       regWrite;
  logic       memWrite;
  logic       branch;
  logic       aluOp;        // Data-processing class
  flagWriteT  flagWrite;
  logic       pcSrc;
  logic [2:0] multControl;  // instr[23:21] of a multiply
  resultSelT  resultSelect;
  logic       rSelect;
  condT       cond;
  instrT      instr;

  modport dec (
    output aluSrc, memToReg, regWrite, memWrite, branch, aluOp, flagWrite,
           pcSrc, multControl, resultSelect, rSelect, cond, instr
  );

  modport pipe (
    input aluSrc, memToReg, regWrite, memWrite, branch, aluOp, flagWrite,
          pcSrc, multControl, resultSelect, rSelect, cond, instr
  );

endinterface

// ==== ctrlPipe.sv ====
`timescale 1ns/100ps

module ctrlPipe
  import isaPkg::*, ctrlPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      stallE,
  input  logic      flushE,
  input  logic      stallM,
  input  logic      stallW,
  input  logic      flushW,
  ctrlBundleIf.pipe bundle,
  input  logic      condEx,
  input  logic      doNotWriteReg,
  input  logic      prevRsrStateD,
  output logic      aluSrcE,
  output logic      aluOpE,
  output dpOpT      aluControlE,
  output flagWriteT flagWriteE,
  output condT      condE,
  output logic      memToRegE,
  output resultSelT resultSelectE,
  output logic      rSelectE,
  output logic      prevRsrStateE,
  output instrT     instrE,
  output logic      pcSrcE,
  output logic      branchTakenE,
  output logic      multEnable,
  output logic      memWriteM,
  output logic      memToRegM,
  output logic      regWriteM,
  output logic      pcSrcM,
  output logic      memToRegW,
  output logic      regWriteW,
  output logic      pcSrcW,
  output logic      pcWrPendingF
);

  logic       regWriteE;
  logic       memWriteE;
  logic       branchE;
  logic [2:0] multControlE;
  logic       regWriteGatedE;
  logic       memWriteGatedE;
  logic       pcSrcGatedE;

  // Execute register, flush wins over stall
  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      aluSrcE       <= 1'b0;
      aluOpE        <= 1'b0;
      flagWriteE    <= '0;
      condE         <= condEq;
      memToRegE     <= 1'b0;
      regWriteE     <= 1'b0;
      memWriteE     <= 1'b0;
      branchE       <= 1'b0;
      pcSrcE        <= 1'b0;
      multControlE  <= '0;
      resultSelectE <= resAlu;
      rSelectE      <= 1'b0;
      prevRsrStateE <= 1'b0;
      instrE        <= '0;
    end else if (!stallE) begin
      aluSrcE       <= bundle.aluSrc;
      aluOpE        <= bundle.aluOp;
      flagWriteE    <= bundle.flagWrite;
      condE         <= bundle.cond;
      memToRegE     <= bundle.memToReg;
      regWriteE     <= bundle.regWrite;
      memWriteE     <= bundle.memWrite;
      branchE       <= bundle.branch;
      pcSrcE        <= bundle.pcSrc;
      multControlE  <= bundle.multControl;
      resultSelectE <= bundle.resultSelect;
      rSelectE      <= bundle.rSelect;
      prevRsrStateE <= prevRsrStateD;
      instrE        <= bundle.instr;
    end
  end

  // Non-DP classes use the adder for address and target
  assign aluControlE = aluOpE ? dpOpT'(instrE[24:21]) : opAdd;

  // Only 32-bit MUL and MLA, long forms set bit 23
  assign multEnable = (instrE[27:25] == 3'b000) & (instrE[7:4] == 4'b1001) &
                      ~multControlE[2];

  assign branchTakenE   = branchE & condEx;
  assign regWriteGatedE = regWriteE & condEx & ~doNotWriteReg;
  assign memWriteGatedE = memWriteE & condEx;
  assign pcSrcGatedE    = pcSrcE & condEx;

  always_ff @(posedge clk) begin
    if (rst) begin
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
    end else if (!stallM) begin  // Memory stall holds
      memWriteM <= memWriteGatedE;
      memToRegM <= memToRegE;
      regWriteM <= regWriteGatedE;
      pcSrcM    <= pcSrcGatedE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flushW) begin
      memToRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else if (!stallW) begin
      memToRegW <= memToRegM;
      regWriteW <= regWriteM;
      pcSrcW    <= pcSrcM;
    end
  end

  // PC write in flight anywhere before Writeback
  assign pcWrPendingF = bundle.pcSrc | pcSrcE | pcSrcM;

endmodule

// ==== ctrlPkg.sv ====
package ctrlPkg;

  // Status flags, N in the top bit
  typedef logic [3:0] flagsT;

  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // Bit 1 enables N and Z, bit 0 enables C and V
  typedef logic [1:0] flagWriteT;

  // ALU function, operand inversion and carry-in come separately
  typedef enum logic [2:0] {
    aluAdd  = 3'b000,
    aluSub  = 3'b001,
    aluAnd  = 3'b010,
    aluOr   = 3'b011,
    aluXor  = 3'b100,
    aluPass = 3'b101
  } aluOpT;

  // Source of the Execute result
  typedef logic [1:0] resultSelT;

  localparam resultSelT resAlu   = 2'b00;
  localparam resultSelT resShift = 2'b01;  // Register-shifted register path
  localparam resultSelT resMult  = 2'b10;

endpackage

// ==== filelist.f ====
isaPkg.sv
ctrlPkg.sv
ctrlBundleIf.sv
mainDecoder.sv
aluDecoder.sv
condUnit.sv
ctrlPipe.sv
armController.sv
armController_sva.sv
tb_armController.sv

// ==== isaPkg.sv ====
package isaPkg;

  typedef logic [31:0] instrT;
  typedef logic [3:0]  regIdxT;

  // Condition field in instr[31:28], 4'b1111 is not a condition here
  typedef enum logic [3:0] {
    condEq = 4'b0000,
    condNe = 4'b0001,
    condCs = 4'b0010,  // Also HS
    condCc = 4'b0011,  // Also LO
    condMi = 4'b0100,
    condPl = 4'b0101,
    condVs = 4'b0110,
    condVc = 4'b0111,
    condHi = 4'b1000,
    condLs = 4'b1001,
    condGe = 4'b1010,
    condLt = 4'b1011,
    condGt = 4'b1100,
    condLe = 4'b1101,
    condAl = 4'b1110
  } condT;

  // Data-processing opcode, instr[24:21]
  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,
    opAdc = 4'b0101,
    opSbc = 4'b0110,
    opRsc = 4'b0111,
    opTst = 4'b1000,  // Flags only
    opTeq = 4'b1001,
    opCmp = 4'b1010,
    opCmn = 4'b1011,
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opBic = 4'b1110,
    opMvn = 4'b1111
  } dpOpT;

endpackage

// ==== mainDecoder.sv ====
`timescale 1ns/100ps

module mainDecoder
  import isaPkg::*, ctrlPkg::*;
(
  input  instrT      instr,
  input  regIdxT     regFileRz,
  output logic [1:0] regSrc,
  output logic [1:0] immSrc,
  output logic       multSelect,
  ctrlBundleIf.dec   bundle
);

  logic [10:0] controls;
  logic        aluSrc;
  logic        memToReg;
  logic        regWrite;
  logic        memWrite;
  logic        branch;
  logic        aluOp;
  logic        isMultiply;
  logic        dpClass;
  logic        rsrSelect;
  regIdxT      destReg;

  assign isMultiply = (instr[7:4] == 4'b1001);
  assign dpClass    = (instr[27:25] == 3'b000);

  // regSrc_immSrc_aluSrc memToReg regWrite memWrite branch aluOp multSelect
  always_comb begin
    case (instr[27:26])
      2'b00: begin
        if (instr[25])
          controls = 11'b00_00_1_0_1_0_0_1_0;  // DP immediate
        else if (isMultiply)
          controls = 11'b00_00_0_0_1_0_0_1_1;  // MUL, MLA
        else
          controls = 11'b00_00_0_0_1_0_0_1_0;  // DP register
      end
      2'b01: begin
        if (instr[20])
          controls = 11'b00_01_1_1_1_0_0_0_0;  // LDR
        else
          controls = 11'b10_01_1_0_0_1_0_0_0;  // STR
      end
      2'b10:   controls = 11'b01_10_1_0_0_0_1_0_0;  // B
      default: controls = '0;                       // Coprocessor space, no effect
    endcase
  end

  assign {regSrc, immSrc, aluSrc, memToReg, regWrite, memWrite, branch, aluOp,
          multSelect} = controls;

  // Multiply keeps its destination in bits 19 to 16
  assign destReg = multSelect ? instr[19:16] : instr[15:12];

  assign rsrSelect = dpClass & instr[4];

  assign bundle.aluSrc    = aluSrc;
  assign bundle.memToReg  = memToReg;
  assign bundle.regWrite  = regWrite;
  assign bundle.memWrite  = memWrite;
  assign bundle.branch    = branch;
  assign bundle.aluOp     = aluOp;
  assign bundle.flagWrite = aluOp ? {instr[20], instr[20]} : 2'b00;  // S bit
  assign bundle.multControl = instr[23:21];

  // R15 as destination redirects fetch, unless the sequencer owns the write
  assign bundle.pcSrc = ((destReg == 4'hF) & regWrite & ~regFileRz[2]) | branch;

  assign bundle.rSelect      = dpClass & ~instr[4];
  assign bundle.resultSelect = multSelect ? resMult : (rsrSelect ? resShift : resAlu);

  assign bundle.cond  = condT'(instr[31:28]);
  assign bundle.instr = instr;

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Compile and run the armController testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log &&
verilator --binary --assert --top-module tb_armController -f filelist.f -o simArm \
  > build.log 2>&1 &&
./obj_dir/simArm +verilator+error+limit+1000 2>&1 | tee sim.log

# Verdict comes from the log only
grep -qF '*** PASSED ***' sim.log && echo "Simulation passed" ||
  { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== tb_armController.sv ====
`timescale 1ns/100ps

module tb_armController
  import isaPkg::*, ctrlPkg::*;
();

  localparam int numInstr      = 400;
  localparam int resetCycles   = 5;
  localparam int timeoutCycles = numInstr + 100;  // Reset and drain fit well inside

  logic       clk;
  logic       rst;
  instrT      instrD;
  flagsT      flagsE;
  regIdxT     regFileRzD;
  logic       prevRsrStateD;
  logic       stallE;
  logic       flushE;
  logic       stallM;
  logic       stallW;
  logic       flushW;
  logic [1:0] regSrcD;
  logic [1:0] immSrcD;
  logic       multSelectD;
  logic       aluSrcE;
  dpOpT       aluControlE;
  aluOpT      aluOperationE;
  logic       cvUpdateE;
  logic       invertBE;
  logic       reverseInputsE;
  logic       aluCarryE;
  resultSelT  resultSelectE;
  logic       rSelectE;
  logic       prevRsrStateE;
  logic       branchTakenE;
  logic       multEnable;
  instrT      instrE;
  flagsT      previousFlagsE;
  logic       memWriteM;
  logic       memToRegE;
  logic       memToRegM;
  logic       regWriteM;
  logic       memToRegW;
  logic       regWriteW;
  logic       pcSrcW;
  logic       pcWrPendingF;

  logic [31:0] lfsrState  = 32'd59;
  int          cycleCount = 0;

  armController i_armController (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsrState = lfsrStep(lfsrState);  // One step per bit
      r[k] = lfsrState[0];
    end
    return r;
  endfunction

  function automatic instrT makeInstr();
    logic [3:0]  cond;
    logic [2:0]  kind;
    logic [31:0] body;
    instrT       word;
    cond = 4'(randBits(4));
    if (cond == 4'hF)
      cond = 4'hE;
    kind = 3'(randBits(3));
    body = randBits(25);
    case (kind)
      3'd0, 3'd1: word = {cond, 3'b001, body[24:0]};  // DP immediate
      3'd2, 3'd3: word = {cond, 3'b000, body[24:8], body[7] & ~body[4], body[6:0]};
      3'd4:       word = {cond, 6'b000000, body[21:8], 4'b1001, body[3:0]};  // MUL, MLA
      3'd5:       word = {cond, 3'b010, body[24:21], 1'b1, body[19:0]};      // LDR
      3'd6:       word = {cond, 3'b010, body[24:21], 1'b0, body[19:0]};      // STR
      default:    word = {cond, 3'b101, body[24:0]};                         // B
    endcase
    return word;
  endfunction

  task automatic stopOnFailure(input string line);
    $display("%s", line);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on failure");
  endtask

  // Bound checker counts its own assertion failures
  always @(negedge clk) begin
    assert (i_armController.svaChecks.failCount == 0)
    else stopOnFailure($sformatf("CHECK FAILED at %0t: assertion in armController_sva fired",
                                 $time));
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
      stopOnFailure($sformatf("Timeout: run did not finish within %0d cycles", timeoutCycles));
  end

  initial begin
    rst           = 1'b1;
    instrD        = '0;
    flagsE        = '0;
    regFileRzD    = '0;
    prevRsrStateD = 1'b0;
    stallE        = 1'b0;
    flushE        = 1'b0;
    stallM        = 1'b0;
    stallW        = 1'b0;
    flushW        = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < numInstr; i++) begin
      instrD        <= makeInstr();
      flagsE        <= 4'(randBits(4));
      regFileRzD    <= 4'(randBits(4));
      prevRsrStateD <= 1'(randBits(1));
      stallE        <= (randBits(3) == 32'd0);  // About one cycle in eight
      flushE        <= (randBits(3) == 32'd0);
      @(posedge clk);
    end
    stallE <= 1'b0;
    flushE <= 1'b0;
    repeat (4) @(posedge clk);  // Drain through Writeback
    if (i_armController.svaChecks.failCount == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stopOnFailure($sformatf("CHECK FAILED at %0t: assertion failures at end of run", $time));
    end
  end

endmodule
